// File: rtl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  typedef struct packed {
    logic lsu_lb;
    logic lsu_lbu;
    logic lsu_lh;
    logic lsu_lhu;
    logic lsu_lw;
    logic lsu_sb;
    logic lsu_sh;
    logic lsu_sw;
  } lsu_op_type;

  typedef enum logic [2:0] {
    op_load,
    op_store,
    op_jal,
    op_jalr,
    op_branch,
    op_auipc
  } op_kind_type;

  localparam logic [7:0] except_instr_addr_misalign = 8'd0;
  localparam logic [7:0] except_load_addr_misalign  = 8'd4;
  localparam logic [7:0] except_load_access_fault   = 8'd5;
  localparam logic [7:0] except_store_addr_misalign = 8'd6;
  localparam logic [7:0] except_store_access_fault  = 8'd7;

endpackage

`default_nettype wire

// File: rtl/apb_pkg.sv
`default_nettype none

package apb_pkg;

  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_access,
    st_resp
  } apb_state_type;

  localparam int apb_addr_w = 32;
  localparam int apb_data_w = 32;
  localparam int apb_strb_w = 4;

endpackage

`default_nettype wire

// File: rtl/agu.sv
`timescale 1ns/1ps
`default_nettype none

module agu import lsu_pkg::*; (
  input  op_kind_type kind,
  input  lsu_op_type  op,
  input  logic [31:0] rdata1,
  input  logic [31:0] imm,
  input  logic [31:0] pc,
  output logic [31:0] address,
  output logic [3:0]  byteenable,
  output logic        exception,
  output logic [7:0]  ecause,
  output logic [31:0] etval
);

  logic misalign;
  logic imem_access;
  logic dmem_access;
  logic pc_relative;

  always_comb begin
    misalign = 1'b0;
    exception = 1'b0;
    ecause = 8'h00;
    etval = 32'h0000_0000;
    byteenable = 4'h0;

    imem_access = (kind == op_jal) || (kind == op_jalr) || (kind == op_branch); // auipc only forms a value
    dmem_access = (kind == op_load) || (kind == op_store);
    pc_relative = (kind == op_jal) || (kind == op_branch) || (kind == op_auipc);

    address = (pc_relative ? pc : rdata1) + imm;
    if (kind == op_jalr) begin
      address[0] = 1'b0;
    end

    if (imem_access) begin
      if (address[0]) misalign = 1'b1; // Targets must sit on a halfword
      else byteenable = 4'hF;
    end

    if (dmem_access) begin
      if (op.lsu_sb || op.lsu_lb || op.lsu_lbu) begin
        byteenable = 4'h1 << address[1:0];
      end
      if (op.lsu_sh || op.lsu_lh || op.lsu_lhu) begin
        case (address[1:0])
          2'd0: byteenable = 4'h3;
          2'd2: byteenable = 4'hC;
          default: misalign = 1'b1;
        endcase
      end
      if (op.lsu_sw || op.lsu_lw) begin
        if (address[1:0] == 2'd0) byteenable = 4'hF;
        else misalign = 1'b1;
      end
    end

    if (misalign) begin
      exception = 1'b1;
      etval = address;
      if (imem_access) ecause = except_instr_addr_misalign;
      else if (kind == op_load) ecause = except_load_addr_misalign;
      else ecause = except_store_addr_misalign;
    end
  end

  // A faulting access never reaches the bus, so no lane may be enabled
  no_lanes_on_exception: assert final (!exception || byteenable == 4'h0);

endmodule

`default_nettype wire

// File: rtl/lsu_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_align import lsu_pkg::*, apb_pkg::*; (
  input  lsu_op_type            op,
  input  logic [1:0]            offset,
  input  logic [31:0]           wdata,
  input  logic [apb_data_w-1:0] prdata,
  output logic [apb_data_w-1:0] pwdata,
  output logic [31:0]           load_data
);

  logic [31:0] shifted;

  // Stores copy the value to every lane and the strobes pick the live ones
  always_comb begin
    if (op.lsu_sb) begin
      pwdata = {4{wdata[7:0]}};
    end else if (op.lsu_sh) begin
      pwdata = {2{wdata[15:0]}};
    end else begin
      pwdata = wdata;
    end
  end

  always_comb begin
    shifted = prdata >> {offset, 3'b000}; // Addressed byte moves to lane 0
    load_data = shifted;
    if (op.lsu_lb) begin
      load_data = {{24{shifted[7]}}, shifted[7:0]};
    end
    if (op.lsu_lbu) begin
      load_data = {24'h00_0000, shifted[7:0]};
    end
    if (op.lsu_lh) begin
      load_data = {{16{shifted[15]}}, shifted[15:0]};
    end
    if (op.lsu_lhu) begin
      load_data = {16'h0000, shifted[15:0]};
    end
  end

endmodule

`default_nettype wire

// File: rtl/apb_timeout.sv
`timescale 1ns/1ps
`default_nettype none

module apb_timeout #(
  parameter int timeout_cycles = 16
) (
  input  logic clock,
  input  logic rst,
  input  logic count,
  output logic expired
);

  localparam int cnt_w = $clog2(timeout_cycles + 1);

  logic [cnt_w-1:0] cnt;

  always_ff @(posedge clock) begin
    if (rst || !count) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign expired = count && (cnt == cnt_w'(timeout_cycles - 1)); // Last allowed wait cycle

  // The FSM must drop count right after expiry or the counter runs past its limit
  cnt_bounded: assert property (@(posedge clock) disable iff (rst)
    cnt <= cnt_w'(timeout_cycles));

endmodule

`default_nettype wire

// File: rtl/lsu_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_fsm import lsu_pkg::*, apb_pkg::*; #(
  parameter int timeout_cycles = 16
) (
  input  logic                  clock,
  input  logic                  rst,
  input  logic                  req_valid,
  input  op_kind_type           req_kind,
  input  lsu_op_type            req_op,
  input  logic [31:0]           req_rdata1,
  input  logic [31:0]           req_imm,
  input  logic [31:0]           req_pc,
  input  logic [31:0]           req_wdata,
  input  logic [31:0]           address,
  input  logic [3:0]            byteenable,
  input  logic                  agu_exception,
  input  logic [7:0]            agu_ecause,
  input  logic [31:0]           agu_etval,
  input  logic [31:0]           load_data,
  input  logic [apb_data_w-1:0] pwdata_aligned,
  input  logic                  pready,
  input  logic [apb_data_w-1:0] prdata,
  input  logic                  pslverr,
  output logic                  req_ready,
  output op_kind_type           kind_q,
  output lsu_op_type            op_q,
  output logic [31:0]           rdata1_q,
  output logic [31:0]           imm_q,
  output logic [31:0]           pc_q,
  output logic [31:0]           wdata_q,
  output logic                  psel,
  output logic                  penable,
  output logic                  pwrite,
  output logic [apb_addr_w-1:0] paddr,
  output logic [apb_data_w-1:0] pwdata,
  output logic [apb_strb_w-1:0] pstrb,
  output logic [apb_data_w-1:0] prdata_q,
  output logic                  resp_valid,
  output logic [31:0]           resp_address,
  output logic [31:0]           resp_rdata,
  output logic                  resp_exception,
  output logic [7:0]            resp_ecause,
  output logic [31:0]           resp_etval
);

  apb_state_type state;
  apb_state_type state_n;
  logic          pending; // Request registered, AGU result valid this cycle
  logic          out_of_reset;
  logic          fault_q;
  logic          expired;
  logic          is_load;

  assign is_load = kind_q == op_load;
  assign req_ready = (state == st_idle) && !pending && out_of_reset;

  always_comb begin
    state_n = state;
    case (state)
      st_idle: begin
        if (pending) begin
          state_n = (agu_exception || !(is_load || kind_q == op_store)) ? st_resp : st_setup;
        end
      end
      st_setup: state_n = st_access;
      st_access: if (pready || expired) state_n = st_resp;
      default: state_n = st_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      state <= st_idle;
      pending <= 1'b0;
      out_of_reset <= 1'b0;
      fault_q <= 1'b0;
    end else begin
      state <= state_n;
      pending <= req_valid && req_ready;
      out_of_reset <= 1'b1;
      if (req_valid && req_ready) fault_q <= 1'b0;
      else if (state == st_access) fault_q <= pready ? pslverr : expired; // Completion wins over expiry
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid && req_ready) begin
      kind_q <= req_kind;
      op_q <= req_op;
      rdata1_q <= req_rdata1;
      imm_q <= req_imm;
      pc_q <= req_pc;
      wdata_q <= req_wdata;
    end
    if (state == st_access && pready) begin
      prdata_q <= prdata;
    end
  end

  apb_timeout #(
    .timeout_cycles(timeout_cycles)
  ) u_apb_timeout (
    .clock  (clock),
    .rst    (rst),
    .count  (state == st_access),
    .expired(expired)
  );

  assign psel = (state == st_setup) || (state == st_access);
  assign penable = state == st_access;
  assign pwrite = kind_q == op_store;
  assign paddr = {address[apb_addr_w-1:2], 2'b00};
  assign pwdata = pwdata_aligned;
  assign pstrb = pwrite ? byteenable : '0;

  assign resp_valid = state == st_resp;
  assign resp_address = address;
  assign resp_exception = agu_exception || fault_q;
  assign resp_rdata = (is_load && !resp_exception) ? load_data : 32'h0000_0000;
  always_comb begin
    if (fault_q) begin
      resp_ecause = is_load ? except_load_access_fault : except_store_access_fault;
      resp_etval = address;
    end else begin
      resp_ecause = agu_ecause;
      resp_etval = agu_etval;
    end
  end

  penable_needs_psel: assert property (@(posedge clock) disable iff (rst)
    penable |-> psel && $past(psel));
  paddr_held: assert property (@(posedge clock) disable iff (rst) penable |-> $stable(paddr));

endmodule

`default_nettype wire

// File: rtl/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*, apb_pkg::*; #(
  parameter int timeout_cycles = 16
) (
  input  logic                  clock,
  input  logic                  rst,
  input  logic                  req_valid,
  input  op_kind_type           req_kind,
  input  lsu_op_type            req_op,
  input  logic [31:0]           req_rdata1,
  input  logic [31:0]           req_imm,
  input  logic [31:0]           req_pc,
  input  logic [31:0]           req_wdata,
  output logic                  req_ready,
  output logic                  resp_valid,
  output logic [31:0]           resp_address,
  output logic [31:0]           resp_rdata,
  output logic                  resp_exception,
  output logic [7:0]            resp_ecause,
  output logic [31:0]           resp_etval,
  output logic                  psel,
  output logic                  penable,
  output logic                  pwrite,
  output logic [apb_addr_w-1:0] paddr,
  output logic [apb_data_w-1:0] pwdata,
  output logic [apb_strb_w-1:0] pstrb,
  input  logic                  pready,
  input  logic [apb_data_w-1:0] prdata,
  input  logic                  pslverr
);

  op_kind_type           kind_q;
  lsu_op_type            op_q;
  logic [31:0]           rdata1_q;
  logic [31:0]           imm_q;
  logic [31:0]           pc_q;
  logic [31:0]           wdata_q;
  logic [31:0]           address;
  logic [3:0]            byteenable;
  logic                  agu_exception;
  logic [7:0]            agu_ecause;
  logic [31:0]           agu_etval;
  logic [31:0]           load_data;
  logic [apb_data_w-1:0] pwdata_aligned;
  logic [apb_data_w-1:0] prdata_q;

  lsu_fsm #(
    .timeout_cycles(timeout_cycles)
  ) u_lsu_fsm (
    .clock(clock), .rst(rst),
    .req_valid(req_valid), .req_kind(req_kind), .req_op(req_op),
    .req_rdata1(req_rdata1), .req_imm(req_imm), .req_pc(req_pc), .req_wdata(req_wdata),
    .address(address), .byteenable(byteenable), .agu_exception(agu_exception),
    .agu_ecause(agu_ecause), .agu_etval(agu_etval),
    .load_data(load_data), .pwdata_aligned(pwdata_aligned),
    .pready(pready), .prdata(prdata), .pslverr(pslverr),
    .req_ready(req_ready),
    .kind_q(kind_q), .op_q(op_q), .rdata1_q(rdata1_q), .imm_q(imm_q),
    .pc_q(pc_q), .wdata_q(wdata_q),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .pstrb(pstrb), .prdata_q(prdata_q),
    .resp_valid(resp_valid), .resp_address(resp_address), .resp_rdata(resp_rdata),
    .resp_exception(resp_exception), .resp_ecause(resp_ecause), .resp_etval(resp_etval)
  );

  agu u_agu (
    .kind(kind_q), .op(op_q), .rdata1(rdata1_q), .imm(imm_q), .pc(pc_q),
    .address(address), .byteenable(byteenable), .exception(agu_exception),
    .ecause(agu_ecause), .etval(agu_etval)
  );

  lsu_align u_lsu_align (
    .op(op_q), .offset(address[1:0]), .wdata(wdata_q), .prdata(prdata_q),
    .pwdata(pwdata_aligned), .load_data(load_data)
  );

endmodule

`default_nettype wire

// File: dv/tb_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu import lsu_pkg::*; ();

  logic        clock;
  logic        rst;
  logic        req_valid;
  op_kind_type req_kind;
  lsu_op_type  req_op;
  logic [31:0] req_rdata1;
  logic [31:0] req_imm;
  logic [31:0] req_pc;
  logic [31:0] req_wdata;
  logic        req_ready;
  logic        resp_valid;
  logic [31:0] resp_address;
  logic [31:0] resp_rdata;
  logic        resp_exception;
  logic [7:0]  resp_ecause;
  logic [31:0] resp_etval;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] paddr;
  logic [31:0] pwdata;
  logic [3:0]  pstrb;
  logic        pready = 1'b0;
  logic [31:0] prdata = 32'h0;
  logic        pslverr = 1'b0;

  logic [31:0]     mem [0:63];
  integer          seed = 35;
  integer          wait_left;
  integer          errors = 0;
  integer          tests = 0;
  logic            timed_out = 1'b0;
  logic            bus_expected = 1'b0; // Aligned memory ops may use the bus
  logic            psel_seen;
  logic            cur_store = 1'b0;
  logic [3:0]      exp_be = 4'h0;
  logic [31:0]     exp_paddr = 32'h0;
  logic [8*32-1:0] cur_name = "none";

  lsu_top #(.timeout_cycles(8)) DUT (
    .clock(clock), .rst(rst), .req_valid(req_valid), .req_kind(req_kind), .req_op(req_op),
    .req_rdata1(req_rdata1), .req_imm(req_imm), .req_pc(req_pc), .req_wdata(req_wdata),
    .req_ready(req_ready), .resp_valid(resp_valid), .resp_address(resp_address),
    .resp_rdata(resp_rdata), .resp_exception(resp_exception), .resp_ecause(resp_ecause),
    .resp_etval(resp_etval), .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .pstrb(pstrb), .pready(pready), .prdata(prdata), .pslverr(pslverr)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5A, 8'hC3 ^ (i[7:0] << 2)};
    end
  end

  // Byte lanes an aligned access of this size and offset should enable
  function automatic [3:0] expected_lanes(input [7:0] op_v, input [1:0] off);
    if (op_v & 8'hC4) expected_lanes = 4'h1 << off;
    else if (op_v & 8'h32) expected_lanes = off[1] ? 4'hC : 4'h3;
    else expected_lanes = 4'hF;
  endfunction

  task automatic present_response(input [31:0] addr);
    if (addr < 32'h2000) begin // Stall region never answers
      pready <= 1'b1;
      pslverr <= (addr >= 32'h1000) && (addr < 32'h1100);
      prdata <= (addr < 32'h100) ? mem[addr[7:2]] : 32'h0;
    end
  endtask

  always @(posedge clock) begin : apb_slave
    integer w;
    if (rst) begin
      pready <= 1'b0;
      pslverr <= 1'b0;
      wait_left <= 0;
    end else if (psel && !penable) begin
      w = $random(seed) & 3;
      wait_left <= w;
      if (w == 0) present_response(paddr);
    end else if (psel && penable && pready) begin
      for (int i = 0; i < 4; i++) begin
        if (pwrite && pstrb[i] && paddr < 32'h100) mem[paddr[7:2]][8*i +: 8] = pwdata[8*i +: 8];
      end
      pready <= 1'b0;
      pslverr <= 1'b0;
    end else if (psel && penable) begin
      if (wait_left <= 1) present_response(paddr);
      wait_left <= wait_left - 1;
    end
  end

  always @(posedge clock) begin : bus_monitor
    if (!rst && psel) begin
      psel_seen = 1'b1;
      if (!bus_expected) begin
        $display("Test %0s raised psel although it must not reach the bus", cur_name);
        errors++;
      end
      if (paddr !== exp_paddr) begin
        $display("FAIL %0s paddr: expected %h, actual %h", cur_name, exp_paddr, paddr);
        errors++;
      end
      if (pwrite !== cur_store) begin
        $display("FAIL %0s pwrite: expected %h, actual %h", cur_name, cur_store, pwrite);
        errors++;
      end
      if (pstrb !== (cur_store ? exp_be : 4'h0)) begin
        $display("FAIL %0s pstrb: expected %h, actual %h", cur_name,
                 cur_store ? exp_be : 4'h0, pstrb);
        errors++;
      end
    end
  end

  task automatic check_value(input [8*32-1:0] name, input string field,
                             input [31:0] expected, input [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %0s %0s: expected %h, actual %h", name, field, expected, actual);
      errors++;
    end
  endtask

  task automatic run_op(input [8*32-1:0] name, input [31:0] col [0:9]);
    integer n;
    logic   done;
    cur_name = name;
    cur_store = col[0] == 1;
    bus_expected = (col[0] <= 1) && !(col[8][0] && (col[9] == 4 || col[9] == 6));
    exp_be = expected_lanes(col[1][7:0], col[6][1:0]);
    exp_paddr = {col[6][31:2], 2'b00};
    psel_seen = 1'b0;
    tests++;
    req_valid <= 1'b1;
    req_kind <= op_kind_type'(col[0][2:0]);
    req_op <= lsu_op_type'(col[1][7:0]);
    req_rdata1 <= col[2];
    req_imm <= col[3];
    req_pc <= col[4];
    req_wdata <= col[5];
    done = 1'b0;
    for (n = 0; n < 100 && !done; n++) begin
      @(posedge clock);
      done = req_ready; // req_valid was already high before this edge
    end
    req_valid <= 1'b0;
    if (!done) begin
      $display("Timeout: test %0s was never accepted by the DUT", name);
      errors++;
      timed_out = 1'b1;
    end else begin
      done = 1'b0;
      for (n = 0; n < 100 && !done; n++) begin
        @(posedge clock);
        done = resp_valid;
      end
      if (!done) begin
        $display("Timeout: test %0s got no response from the DUT", name);
        errors++;
        timed_out = 1'b1;
      end else begin
        check_value(name, "address", col[6], resp_address);
        check_value(name, "exception", col[8], {31'b0, resp_exception});
        if (col[8][0]) check_value(name, "ecause", col[9], {24'b0, resp_ecause});
        if (col[8][0]) check_value(name, "etval", col[6], resp_etval);
        if (col[0] == 0 && !col[8][0]) check_value(name, "rdata", col[7], resp_rdata);
        if (bus_expected && !psel_seen) begin
          $display("Test %0s finished without any APB transfer", name);
          errors++;
        end
      end
    end
  endtask

  initial begin : stimulus
    integer          fd;
    integer          r;
    logic            done;
    logic [8*32-1:0] tok;
    logic [8*200-1:0] rest;
    logic [31:0]     col [0:9];
    rst = 1'b1;
    req_valid = 1'b0;
    req_kind = op_load;
    req_op = '0;
    req_rdata1 = 32'h0;
    req_imm = 32'h0;
    req_pc = 32'h0;
    req_wdata = 32'h0;
    repeat (3) @(posedge clock);
    rst <= 1'b0;
    fd = $fopen("dv/lsu_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file dv/lsu_input.txt");
      errors++;
    end else begin
      done = 1'b0;
      while (!done) begin
        r = $fscanf(fd, "%s", tok);
        if (r != 1) begin
          done = 1'b1;
        end else if (tok == "#") begin
          r = $fgets(rest, fd); // Skip the rest of a comment line
        end else begin
          r = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", col[0], col[1], col[2], col[3],
                      col[4], col[5], col[6], col[7], col[8], col[9]);
          if (r != 10) begin
            $display("Stimulus line for test %0s is malformed", tok);
            errors++;
            done = 1'b1;
          end else begin
            run_op(tok, col);
            done = timed_out;
          end
        end
      end
      $fclose(fd);
    end
    $display("Ran %0d operations with %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
rtl/lsu_pkg.sv
rtl/apb_pkg.sv
rtl/agu.sv
rtl/lsu_align.sv
rtl/apb_timeout.sv
rtl/lsu_fsm.sv
rtl/lsu_top.sv
dv/tb_lsu.sv

// File: dv/lsu_input.txt
# name kind op rdata1 imm pc wdata exp_address exp_rdata exp_exception exp_ecause (all hex)
# kind 0 load 1 store 2 jal 3 jalr 4 branch 5 auipc; op lb 80 lbu 40 lh 20 lhu 10 lw 08 sb 04 sh 02 sw 01
sw_init     1 01 00000030 00000010 00000000 11223344 00000040 00000000 0 00
lw_init     0 08 00000040 00000000 00000000 00000000 00000040 11223344 0 00
sb_off1     1 04 00000040 00000001 00000000 000000F5 00000041 00000000 0 00
lb_off1     0 80 00000040 00000001 00000000 00000000 00000041 FFFFFFF5 0 00
lbu_off1    0 40 00000041 00000000 00000000 00000000 00000041 000000F5 0 00
sb_off3     1 04 00000044 FFFFFFFF 00000000 12345680 00000043 00000000 0 00
lb_off3     0 80 00000043 00000000 00000000 00000000 00000043 FFFFFF80 0 00
lbu_off0    0 40 00000040 00000000 00000000 00000000 00000040 00000044 0 00
lb_off2     0 80 00000042 00000000 00000000 00000000 00000042 00000022 0 00
sh_off2     1 02 00000042 00000000 00000000 0000A5B6 00000042 00000000 0 00
lh_off2     0 20 00000042 00000000 00000000 00000000 00000042 FFFFA5B6 0 00
lhu_off2    0 10 00000042 00000000 00000000 00000000 00000042 0000A5B6 0 00
sh_off0     1 02 00000040 00000000 00000000 DEAD8234 00000040 00000000 0 00
lh_off0     0 20 00000040 00000000 00000000 00000000 00000040 FFFF8234 0 00
lhu_off0    0 10 00000040 00000000 00000000 00000000 00000040 00008234 0 00
lw_mixed    0 08 00000040 00000000 00000000 00000000 00000040 A5B68234 0 00
sw_clear    1 01 00000044 00000000 00000000 00000000 00000044 00000000 0 00
sb_off0     1 04 00000044 00000000 00000000 0000007F 00000044 00000000 0 00
sb_off2     1 04 00000044 00000002 00000000 0000009C 00000046 00000000 0 00
lw_bytes    0 08 00000044 00000000 00000000 00000000 00000044 009C007F 0 00
lb_neg2     0 80 00000046 00000000 00000000 00000000 00000046 FFFFFF9C 0 00
jal_fwd     2 00 00000000 00000020 00000100 00000000 00000120 00000000 0 00
jal_odd     2 00 00000000 00000021 00000100 00000000 00000121 00000000 1 00
jalr_clr    3 00 00000203 00000004 00000000 00000000 00000206 00000000 0 00
branch_back 4 00 00000000 FFFFFFF0 00000400 00000000 000003F0 00000000 0 00
auipc_hi    5 00 00000000 12345000 00001000 00000000 12346000 00000000 0 00
lh_mis1     0 20 00000041 00000000 00000000 00000000 00000041 00000000 1 04
lhu_mis3    0 10 00000043 00000000 00000000 00000000 00000043 00000000 1 04
lw_mis2     0 08 00000042 00000000 00000000 00000000 00000042 00000000 1 04
sh_mis3     1 02 00000047 00000000 00000000 00001234 00000047 00000000 1 06
sw_mis1     1 01 00000045 00000000 00000000 CAFE0001 00000045 00000000 1 06
sw_mis3     1 01 0000004B 00000000 00000000 CAFE0003 0000004B 00000000 1 06
lw_slverr   0 08 00001010 00000000 00000000 00000000 00001010 00000000 1 05
sw_slverr   1 01 00001020 00000000 00000000 0BADF00D 00001020 00000000 1 07
lw_stall    0 08 00002000 00000000 00000000 00000000 00002000 00000000 1 05
sb_stall    1 04 00002001 00000000 00000000 00000055 00002001 00000000 1 07
lw_recover  0 08 00000040 00000000 00000000 00000000 00000040 A5B68234 0 00
